/* rtl/blake_pkg.sv */
// ==========================================================
// shared types and constants for the BLAKE-256 search core
// imported by every RTL block and by the testbench
// ==========================================================

package blake_pkg;

   typedef logic [31:0] word_t;

   // v0..v15 working vector and m0..m15 message block
   typedef word_t [15:0] state_t;
   typedef word_t [15:0] msg_t;

   // one search job from the host
   typedef struct packed {
      word_t [7:0] midstate;
      word_t [2:0] header;
      word_t       nonce;
   } job_t;

   // 65-bit result returned per job
   typedef struct packed {
      word_t nonce;
      word_t h7;
      logic  match;
   } result_t;

   // pi-derived constants C0..C15
   localparam word_t blake_const [16] = '{
      32'h243F6A88, 32'h85A308D3, 32'h13198A2E, 32'h03707344,
      32'hA4093822, 32'h299F31D0, 32'h082EFA98, 32'hEC4E6C89,
      32'h452821E6, 32'h38D01377, 32'hBE5466CF, 32'h34E90C6C,
      32'hC0AC29B7, 32'hC97C50DD, 32'h3F84D5B5, 32'hB5470917
   };

   // message permutation, one row per round
   localparam logic [3:0] sigma [10][16] = '{
      '{ 0,  1,  2,  3,  4,  5,  6,  7,  8,  9, 10, 11, 12, 13, 14, 15},
      '{14, 10,  4,  8,  9, 15, 13,  6,  1, 12,  0,  2, 11,  7,  5,  3},
      '{11,  8, 12,  0,  5,  2, 15, 13, 10, 14,  3,  6,  7,  1,  9,  4},
      '{ 7,  9,  3,  1, 13, 12, 11, 14,  2,  6,  5, 10,  4,  0, 15,  8},
      '{ 9,  0,  5,  7,  2,  4, 10, 15, 14,  1, 11, 12,  6,  8,  3, 13},
      '{ 2, 12,  6, 10,  0, 11,  8,  3,  4, 13,  7,  5, 15, 14,  1,  9},
      '{12,  5,  1, 15, 14, 13,  4, 10,  0,  7,  6,  3,  9,  2,  8, 11},
      '{13, 11,  7, 14, 12,  1,  3,  9,  5,  0, 15,  4,  8,  6,  2, 10},
      '{ 6, 15, 14,  9, 11,  3,  0,  8, 12,  2, 13,  7,  1,  4, 10,  5},
      '{10,  2,  8,  4,  7,  6,  1,  5, 15, 11,  9, 14,  3, 12, 13,  0}
   };

   // reduced round count used for mining
   localparam int num_rounds = 8;

   // final block of an 80-byte header
   localparam word_t block_count = 32'd640;
   localparam word_t pad_word4   = 32'h80000000;
   localparam word_t len_word13  = 32'h00000001;
   localparam word_t len_word15  = 32'h00000280;

   // low bits of h7 that must be zero for a hit
   localparam int match_bits = 32;

   // G rotations
   localparam int rot_a = 16;
   localparam int rot_b = 12;
   localparam int rot_c = 8;
   localparam int rot_d = 7;

   // init stage, four stages per round, result register
   localparam int pipe_latency = 1 + 4 * num_rounds + 1;

endpackage

/* rtl/blake_g.sv */
// ==========================================================
// BLAKE-256 G mixing function, split over two register stages
// ==========================================================
`timescale 1ns/1ps

module blake_g (
   input  logic             clk,
   input  logic             pipe_en_i,
   input  blake_pkg::word_t a_i,
   input  blake_pkg::word_t b_i,
   input  blake_pkg::word_t c_i,
   input  blake_pkg::word_t d_i,
   input  blake_pkg::word_t m_even_i,
   input  blake_pkg::word_t m_odd_i,
   input  blake_pkg::word_t k_even_i,
   input  blake_pkg::word_t k_odd_i,
   output blake_pkg::word_t a_o,
   output blake_pkg::word_t b_o,
   output blake_pkg::word_t c_o,
   output blake_pkg::word_t d_o
);
   import blake_pkg::*;

   word_t a1, b1, c1, d1, bx1, dx1;
   word_t a_q, b_q, c_q, d_q;
   word_t mk_q;
   word_t a2, b2, c2, d2, bx2, dx2;

   // first half with rotations 16 and 12
   always_comb begin
      a1  = a_i + b_i + (m_even_i ^ k_odd_i);
      dx1 = d_i ^ a1;
      d1  = {dx1[rot_a-1:0], dx1[31:rot_a]};
      c1  = c_i + d1;
      bx1 = b_i ^ c1;
      b1  = {bx1[rot_b-1:0], bx1[31:rot_b]};
   end

   always_ff @(posedge clk) begin
      if (pipe_en_i) begin
         a_q  <= a1;
         b_q  <= b1;
         c_q  <= c1;
         d_q  <= d1;
         // odd message term lines up with the second half
         mk_q <= m_odd_i ^ k_even_i;
      end
   end

   // second half with rotations 8 and 7
   always_comb begin
      a2  = a_q + b_q + mk_q;
      dx2 = d_q ^ a2;
      d2  = {dx2[rot_c-1:0], dx2[31:rot_c]};
      c2  = c_q + d2;
      bx2 = b_q ^ c2;
      b2  = {bx2[rot_d-1:0], bx2[31:rot_d]};
   end

   always_ff @(posedge clk) begin
      if (pipe_en_i) begin
         a_o <= a2;
         b_o <= b2;
         c_o <= c2;
         d_o <= d2;
      end
   end

endmodule

/* rtl/blake_round.sv */
// ==========================================================
// one unrolled BLAKE-256 round, column then diagonal layer
// four register stages, job sideband delayed alongside
// ==========================================================
`timescale 1ns/1ps

module blake_round #(
   parameter int round_idx = 0
) (
   input  logic              clk,
   input  logic              rst_i,
   input  logic              pipe_en_i,
   input  logic              valid_i,
   input  blake_pkg::state_t state_i,
   input  blake_pkg::msg_t   msg_i,
   input  blake_pkg::word_t  nonce_i,
   input  blake_pkg::word_t  iv7_i,
   output logic              valid_o,
   output blake_pkg::state_t state_o,
   output blake_pkg::msg_t   msg_o,
   output blake_pkg::word_t  nonce_o,
   output blake_pkg::word_t  iv7_o
);
   import blake_pkg::*;

   state_t     mid_state;
   logic [3:0] valid_q;
   msg_t       msg_q [4];
   word_t      nonce_q [4];
   word_t      iv7_q [4];

   // column layer on (i, 4+i, 8+i, 12+i)
   for (genvar i = 0; i < 4; i++) begin : g_col
      blake_g i_g (
         .clk      (clk),
         .pipe_en_i(pipe_en_i),
         .a_i      (state_i[i]),
         .b_i      (state_i[4+i]),
         .c_i      (state_i[8+i]),
         .d_i      (state_i[12+i]),
         .m_even_i (msg_i[sigma[round_idx % 10][2*i]]),
         .m_odd_i  (msg_i[sigma[round_idx % 10][2*i+1]]),
         .k_even_i (blake_const[sigma[round_idx % 10][2*i]]),
         .k_odd_i  (blake_const[sigma[round_idx % 10][2*i+1]]),
         .a_o      (mid_state[i]),
         .b_o      (mid_state[4+i]),
         .c_o      (mid_state[8+i]),
         .d_o      (mid_state[12+i])
      );
   end

   // diagonal layer, message taken two stages late
   for (genvar i = 0; i < 4; i++) begin : g_diag
      blake_g i_g (
         .clk      (clk),
         .pipe_en_i(pipe_en_i),
         .a_i      (mid_state[i]),
         .b_i      (mid_state[4+(i+1)%4]),
         .c_i      (mid_state[8+(i+2)%4]),
         .d_i      (mid_state[12+(i+3)%4]),
         .m_even_i (msg_q[1][sigma[round_idx % 10][2*i+8]]),
         .m_odd_i  (msg_q[1][sigma[round_idx % 10][2*i+9]]),
         .k_even_i (blake_const[sigma[round_idx % 10][2*i+8]]),
         .k_odd_i  (blake_const[sigma[round_idx % 10][2*i+9]]),
         .a_o      (state_o[i]),
         .b_o      (state_o[4+(i+1)%4]),
         .c_o      (state_o[8+(i+2)%4]),
         .d_o      (state_o[12+(i+3)%4])
      );
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         valid_q <= '0;
      end else if (pipe_en_i) begin
         valid_q <= {valid_q[2:0], valid_i};
      end
   end

   // sideband shift chain
   always_ff @(posedge clk) begin
      if (pipe_en_i) begin
         msg_q[0]   <= msg_i;
         nonce_q[0] <= nonce_i;
         iv7_q[0]   <= iv7_i;
         for (int s = 1; s < 4; s++) begin
            msg_q[s]   <= msg_q[s-1];
            nonce_q[s] <= nonce_q[s-1];
            iv7_q[s]   <= iv7_q[s-1];
         end
      end
   end

   assign valid_o = valid_q[3];
   assign msg_o   = msg_q[3];
   assign nonce_o = nonce_q[3];
   assign iv7_o   = iv7_q[3];

endmodule

/* rtl/blake_init.sv */
// ==========================================================
// first pipe stage, pads the header block and loads v0..v15
// ==========================================================
`timescale 1ns/1ps

module blake_init (
   input  logic              clk,
   input  logic              rst_i,
   input  logic              pipe_en_i,
   input  logic              job_valid_i,
   input  blake_pkg::job_t   job_i,
   output logic              valid_o,
   output blake_pkg::state_t state_o,
   output blake_pkg::msg_t   msg_o,
   output blake_pkg::word_t  nonce_o,
   output blake_pkg::word_t  iv7_o
);
   import blake_pkg::*;

   msg_t   msg_d;
   state_t state_d;

   always_comb begin
      // final block, mostly zero
      msg_d     = '0;
      msg_d[0]  = job_i.header[0];
      msg_d[1]  = job_i.header[1];
      msg_d[2]  = job_i.header[2];
      msg_d[3]  = job_i.nonce;
      msg_d[4]  = pad_word4;
      msg_d[13] = len_word13;
      msg_d[15] = len_word15;

      for (int i = 0; i < 8; i++) begin
         state_d[i] = job_i.midstate[i];
      end
      for (int i = 8; i < 12; i++) begin
         state_d[i] = blake_const[i-8];
      end
      // counter high word is zero, salt is zero
      state_d[12] = blake_const[4] ^ block_count;
      state_d[13] = blake_const[5] ^ block_count;
      state_d[14] = blake_const[6];
      state_d[15] = blake_const[7];
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         valid_o <= 1'b0;
      end else if (pipe_en_i) begin
         valid_o <= job_valid_i;
      end
   end

   always_ff @(posedge clk) begin
      if (pipe_en_i) begin
         state_o <= state_d;
         msg_o   <= msg_d;
         nonce_o <= job_i.nonce;
         iv7_o   <= job_i.midstate[7];
      end
   end

endmodule

/* rtl/blake_finalize.sv */
// ==========================================================
// last pipe stage, forms h7 and the match flag
// ==========================================================
`timescale 1ns/1ps

module blake_finalize (
   input  logic               clk,
   input  logic               rst_i,
   input  logic               pipe_en_i,
   input  logic               valid_i,
   input  blake_pkg::state_t  state_i,
   input  blake_pkg::word_t   nonce_i,
   input  blake_pkg::word_t   iv7_i,
   output logic               res_valid_o,
   output blake_pkg::result_t res_o
);
   import blake_pkg::*;

   word_t h7;

   // salt is zero, so only iv7 and v7, v15 remain
   assign h7 = iv7_i ^ state_i[7] ^ state_i[15];

   always_ff @(posedge clk) begin
      if (rst_i) begin
         res_valid_o <= 1'b0;
      end else if (pipe_en_i) begin
         res_valid_o <= valid_i;
      end
   end

   always_ff @(posedge clk) begin
      if (pipe_en_i) begin
         res_o.nonce <= nonce_i;
         res_o.h7    <= h7;
         res_o.match <= (h7[match_bits-1:0] == '0);
      end
   end

endmodule

/* rtl/blake_core.sv */
// ==========================================================
// BLAKE-256 search core top, valid/ready job in, result out
// whole pipe stalls while a result waits for the host
// ==========================================================
`timescale 1ns/1ps

module blake_core (
   input  logic               clk,
   input  logic               rst_i,
   input  logic               job_valid_i,
   input  blake_pkg::job_t    job_i,
   output logic               job_ready_o,
   output logic               res_valid_o,
   output blake_pkg::result_t res_o,
   input  logic               res_ready_i
);
   import blake_pkg::*;

   logic   pipe_en;

   // stage s feeds round s, the last entry feeds finalize
   logic   valid_s [num_rounds+1];
   state_t state_s [num_rounds+1];
   msg_t   msg_s   [num_rounds+1];
   word_t  nonce_s [num_rounds+1];
   word_t  iv7_s   [num_rounds+1];

   // advance unless a result is stuck at the output
   assign pipe_en     = ~res_valid_o | res_ready_i;
   assign job_ready_o = pipe_en;

   blake_init i_init (
      .clk        (clk),
      .rst_i      (rst_i),
      .pipe_en_i  (pipe_en),
      .job_valid_i(job_valid_i),
      .job_i      (job_i),
      .valid_o    (valid_s[0]),
      .state_o    (state_s[0]),
      .msg_o      (msg_s[0]),
      .nonce_o    (nonce_s[0]),
      .iv7_o      (iv7_s[0])
   );

   for (genvar r = 0; r < num_rounds; r++) begin : g_round
      blake_round #(
         .round_idx(r)
      ) i_round (
         .clk      (clk),
         .rst_i    (rst_i),
         .pipe_en_i(pipe_en),
         .valid_i  (valid_s[r]),
         .state_i  (state_s[r]),
         .msg_i    (msg_s[r]),
         .nonce_i  (nonce_s[r]),
         .iv7_i    (iv7_s[r]),
         .valid_o  (valid_s[r+1]),
         .state_o  (state_s[r+1]),
         .msg_o    (msg_s[r+1]),
         .nonce_o  (nonce_s[r+1]),
         .iv7_o    (iv7_s[r+1])
      );
   end

   blake_finalize i_finalize (
      .clk        (clk),
      .rst_i      (rst_i),
      .pipe_en_i  (pipe_en),
      .valid_i    (valid_s[num_rounds]),
      .state_i    (state_s[num_rounds]),
      .nonce_i    (nonce_s[num_rounds]),
      .iv7_i      (iv7_s[num_rounds]),
      .res_valid_o(res_valid_o),
      .res_o      (res_o)
   );

endmodule

/* include/blake_ref_model.svh */
// ==========================================================
// software BLAKE-256 model giving the expected h7 of a job
// ==========================================================
`ifndef BLAKE_REF_MODEL_SVH
`define BLAKE_REF_MODEL_SVH

function automatic blake_pkg::word_t rotate_right(input blake_pkg::word_t x, input int n);
   return (x >> n) | (x << (32 - n));
endfunction

function automatic blake_pkg::word_t expected_h7(input blake_pkg::job_t job);
   blake_pkg::word_t m [16];
   blake_pkg::word_t v [16];
   int ia, ib, ic, id, e0, e1;

   m     = '{default: '0};
   m[0]  = job.header[0];
   m[1]  = job.header[1];
   m[2]  = job.header[2];
   m[3]  = job.nonce;
   m[4]  = blake_pkg::pad_word4;
   m[13] = blake_pkg::len_word13;
   m[15] = blake_pkg::len_word15;

   for (int i = 0; i < 8; i++) begin
      v[i]   = job.midstate[i];
      v[i+8] = blake_pkg::blake_const[i];
   end
   v[12] = v[12] ^ blake_pkg::block_count;
   v[13] = v[13] ^ blake_pkg::block_count;

   for (int r = 0; r < blake_pkg::num_rounds; r++) begin
      // g 0..3 columns, g 4..7 diagonals
      for (int g = 0; g < 8; g++) begin
         ia = g % 4;
         ib = (g < 4) ? 4 + g : 4 + (g + 1) % 4;
         ic = (g < 4) ? 8 + g : 8 + (g + 2) % 4;
         id = (g < 4) ? 12 + g : 12 + (g + 3) % 4;
         e0 = blake_pkg::sigma[r % 10][2*g];
         e1 = blake_pkg::sigma[r % 10][2*g+1];
         v[ia] = v[ia] + v[ib] + (m[e0] ^ blake_pkg::blake_const[e1]);
         v[id] = rotate_right(v[id] ^ v[ia], blake_pkg::rot_a);
         v[ic] = v[ic] + v[id];
         v[ib] = rotate_right(v[ib] ^ v[ic], blake_pkg::rot_b);
         v[ia] = v[ia] + v[ib] + (m[e1] ^ blake_pkg::blake_const[e0]);
         v[id] = rotate_right(v[id] ^ v[ia], blake_pkg::rot_c);
         v[ic] = v[ic] + v[id];
         v[ib] = rotate_right(v[ib] ^ v[ic], blake_pkg::rot_d);
      end
   end

   return job.midstate[7] ^ v[7] ^ v[15];
endfunction

`endif

/* test/tb_blake_core.sv */
// ==========================================================
// testbench for the BLAKE-256 search core, table driven
// checks h7, nonce, match flag, latency and back-pressure
// ==========================================================
`timescale 1ns/1ps

module tb_blake_core;
   import blake_pkg::*;

   `include "blake_ref_model.svh"

   localparam int num_jobs        = 32;
   localparam int timed_jobs      = 16;
   localparam int watchdog_cycles = num_jobs * 4 + pipe_latency + 100;

   logic    clk;
   logic    rst_i;
   logic    job_valid_i;
   job_t    job_i;
   logic    job_ready_o;
   logic    res_valid_o;
   result_t res_o;
   logic    res_ready_i;

   // stimulus table and expected h7 per entry
   job_t    job_tab [num_jobs];
   word_t   exp_tab [num_jobs];

   // scoreboard of accepted jobs, oldest first
   int      exp_q [$];
   int      acc_q [$];
   bit      timed_q [$];

   integer  seed = 2;
   int      cyc = 0;
   int      res_count = 0;
   bit      rand_ready = 1'b0;
   bit      held = 1'b0;
   result_t held_res;

   blake_core i_blake_core (
      .clk        (clk),
      .rst_i      (rst_i),
      .job_valid_i(job_valid_i),
      .job_i      (job_i),
      .job_ready_o(job_ready_o),
      .res_valid_o(res_valid_o),
      .res_o      (res_o),
      .res_ready_i(res_ready_i)
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   // host side ready, random once the timed phase is over
   always @(posedge clk) begin
      #1;
      if (rand_ready) begin
         res_ready_i = (($random(seed) & 1) != 0);
      end else begin
         res_ready_i = 1'b1;
      end
   end

   task automatic abort_run();
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic word_check(input string what, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("ERR %0t ns: %s got %h expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic flag_check(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERR %0t ns: %s got %b expected %b", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic hold_check(input result_t got, input result_t exp);
      if (got !== exp) begin
         $display("ERR %0t ns: res_o changed while stalled, got %h expected %h",
                  $time, got, exp);
         abort_run();
      end
   endtask

   task automatic latency_check(input int got, input int exp);
      if (got != exp) begin
         $display("ERR %0t ns: result latency got %0d expected %0d", $time, got, exp);
         abort_run();
      end
   endtask

   task automatic fill_table();
      for (int i = 0; i < num_jobs; i++) begin
         for (int w = 0; w < 8; w++) begin
            job_tab[i].midstate[w] = $random(seed);
         end
         for (int w = 0; w < 3; w++) begin
            job_tab[i].header[w] = $random(seed);
         end
         job_tab[i].nonce = $random(seed);
      end
      // fixed patterns ahead of the random entries
      job_tab[0]          = '0;
      job_tab[1].midstate = '1;
      job_tab[1].header   = '0;
      job_tab[1].nonce    = 32'h00000001;
      job_tab[2].midstate = {32'h5BE0CD19, 32'h1F83D9AB, 32'h9B05688C, 32'h510E527F,
                             32'hA54FF53A, 32'h3C6EF372, 32'hBB67AE85, 32'h6A09E667};
      job_tab[2].header   = {32'h4D2A9C17, 32'h1B8E0F33, 32'h5E6F7A8B};
      job_tab[2].nonce    = 32'h12345678;
      job_tab[3].midstate = {8{32'hA5A5A5A5}};
      job_tab[3].header   = {3{32'h5A5A5A5A}};
      job_tab[3].nonce    = 32'hFFFFFFFF;
      // walking ones
      for (int w = 0; w < 8; w++) begin
         job_tab[4].midstate[w] = 32'h1 << (4 * w);
      end
      for (int w = 0; w < 3; w++) begin
         job_tab[4].header[w] = 32'h80000000 >> w;
      end
      job_tab[4].nonce    = 32'h80000000;
      job_tab[5].midstate = {8{32'h0F0F0F0F}};
      job_tab[5].header   = '0;
      job_tab[5].nonce    = 32'hDEADBEEF;
      for (int i = 0; i < num_jobs; i++) begin
         exp_tab[i] = expected_h7(job_tab[i]);
      end
   endtask

   // called just after a rising edge, returns just after the accepting edge
   task automatic send_job(input int idx, input bit timed);
      bit taken;
      taken       = 1'b0;
      job_valid_i = 1'b1;
      job_i       = job_tab[idx];
      while (!taken) begin
         @(negedge clk);
         if (timed) begin
            flag_check("job_ready_o back-to-back", job_ready_o, 1'b1);
         end
         if (job_ready_o) begin
            taken = 1'b1;
            exp_q.push_back(idx);
            acc_q.push_back(cyc + 1);
            timed_q.push_back(timed);
         end
         @(posedge clk);
         #1;
      end
   endtask

   // output side, sampled mid-cycle where everything is settled
   always @(negedge clk) begin : monitor
      int idx;
      int acc;
      bit timed;
      if (!rst_i) begin
         if (held) begin
            flag_check("res_valid_o while stalled", res_valid_o, 1'b1);
            hold_check(res_o, held_res);
         end
         if (!res_valid_o) begin
            flag_check("job_ready_o with empty output", job_ready_o, 1'b1);
         end else if (!res_ready_i) begin
            flag_check("job_ready_o while stalled", job_ready_o, 1'b0);
         end
         if (res_valid_o && exp_q.size() == 0) begin
            $display("result valid at %0t ns with no job outstanding", $time);
            abort_run();
         end
         if (res_valid_o && res_ready_i) begin
            idx   = exp_q.pop_front();
            acc   = acc_q.pop_front();
            timed = timed_q.pop_front();
            word_check("nonce", res_o.nonce, job_tab[idx].nonce);
            word_check("h7", res_o.h7, exp_tab[idx]);
            flag_check("match", res_o.match, exp_tab[idx][match_bits-1:0] == '0);
            if (timed) begin
               latency_check(cyc + 1 - acc, pipe_latency);
            end
            res_count++;
         end
         held     = res_valid_o && !res_ready_i;
         held_res = res_o;
      end
   end

   initial begin
      #(watchdog_cycles * 100);
      $display("timeout after %0d clock cycles, %0d results still missing",
               watchdog_cycles, num_jobs - res_count);
      abort_run();
   end

   initial begin
      clk         = 1'b0;
      rst_i       = 1'b1;
      job_valid_i = 1'b0;
      job_i       = '0;
      res_ready_i = 1'b1;
      fill_table();
      repeat (2) @(posedge clk);
      #1;
      rst_i = 1'b0;
      // idle cycles, output must stay empty
      repeat (3) begin
         @(posedge clk);
         #1;
      end
      for (int i = 0; i < timed_jobs; i++) begin
         send_job(i, 1'b1);
      end
      job_valid_i = 1'b0;
      // timed results leave before the host starts stalling
      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
      rand_ready = 1'b1;
      @(posedge clk);
      #1;
      for (int i = timed_jobs; i < num_jobs; i++) begin
         if (i % 3 == 0) begin
            job_valid_i = 1'b0;
            @(posedge clk);
            #1;
         end
         send_job(i, 1'b0);
      end
      job_valid_i = 1'b0;
      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
      // a few more cycles to catch duplicate results
      repeat (5) @(negedge clk);
      if (res_count != num_jobs) begin
         $display("got %0d results for %0d jobs", res_count, num_jobs);
         abort_run();
      end else begin
         $display("RESULT: PASS");
         $finish;
      end
   end

endmodule

/* filelist.f */
+incdir+include
rtl/blake_pkg.sv
rtl/blake_g.sv
rtl/blake_round.sv
rtl/blake_init.sv
rtl/blake_finalize.sv
rtl/blake_core.sv
test/tb_blake_core.sv

/* Bender.yml */
package:
  name: blake_core

sources:
  # package first, then leaf blocks, then the top level
  - rtl/blake_pkg.sv
  - rtl/blake_g.sv
  - rtl/blake_round.sv
  - rtl/blake_init.sv
  - rtl/blake_finalize.sv
  - rtl/blake_core.sv

  - target: test
    include_dirs:
      - include
    files:
      - test/tb_blake_core.sv
